// File: src/display_pkg.sv
/*
 * 640x480 VGA raster timing, coordinate type and 16:9 letterbox bounds.
 * Shared by display timing, the framebuffer readout and the testbench.
 */
`default_nettype none

package display_pkg;

    localparam int cordw = 16;                     // coordinate width
    typedef logic signed [cordw-1:0] coord_t;      // signed screen/fb coordinate

    // horizontal timing in pixels
    localparam coord_t h_active = 640;
    localparam coord_t h_front  = 16;
    localparam coord_t h_sync   = 96;
    localparam coord_t h_back   = 48;
    localparam coord_t h_total  = h_active + h_front + h_sync + h_back;  // 800

    // vertical timing in lines
    localparam coord_t v_active = 480;
    localparam coord_t v_front  = 10;
    localparam coord_t v_sync   = 2;
    localparam coord_t v_back   = 33;
    localparam coord_t v_total  = v_active + v_front + v_sync + v_back;  // 525

    localparam logic sync_on = 1'b0;               // both syncs active low

    localparam coord_t lb_top    = 60;             // first image row
    localparam coord_t lb_bottom = 420;            // one past last image row

endpackage

`default_nettype wire

// File: src/draw_pkg.sv
/*
 * Framebuffer geometry, colour format, palette and the border line jobs.
 * Used by the line sequencer, line drawer and framebuffer.
 */
`default_nettype none

package draw_pkg;

    localparam int fb_width  = 320;
    localparam int fb_height = 180;
    localparam int fb_scale  = 2;                      // screen pixels per fb pixel
    localparam int fb_pixels = fb_width * fb_height;
    localparam int fb_addrw  = $clog2(fb_pixels);

    localparam int cidxw = 4;                          // colour index bits
    localparam int chanw = 4;                          // bits per colour channel

    // 12-bit RGB, red in the top nibble
    localparam logic [3*chanw-1:0] palette [2**cidxw] = '{
        12'h000, 12'h125, 12'h725, 12'h085,
        12'hA53, 12'h555, 12'hCCC, 12'hFFF,
        12'hF00, 12'hFA0, 12'hFF0, 12'h0F0,
        12'h00F, 12'h87A, 12'hF7A, 12'hFCA
    };

    localparam logic [cidxw-1:0] cidx_black  = 4'h0;
    localparam logic [cidxw-1:0] cidx_red    = 4'h8;
    localparam logic [cidxw-1:0] cidx_yellow = 4'hA;
    localparam logic [cidxw-1:0] cidx_green  = 4'hB;
    localparam logic [cidxw-1:0] cidx_blue   = 4'hC;

    typedef struct packed {
        display_pkg::coord_t x0;
        display_pkg::coord_t y0;
        display_pkg::coord_t x1;
        display_pkg::coord_t y1;
        logic [cidxw-1:0]    cidx;
    } line_t;

    localparam int line_cnt = 4;
    localparam int line_idw = $clog2(line_cnt);

    // clockwise border, later lines overwrite the shared corners
    localparam line_t line_table [line_cnt] = '{
        '{x0: 0,   y0: 0,   x1: 319, y1: 0,   cidx: cidx_red},
        '{x0: 319, y0: 0,   x1: 319, y1: 179, cidx: cidx_yellow},
        '{x0: 319, y0: 179, x1: 0,   y1: 179, cidx: cidx_green},
        '{x0: 0,   y0: 179, x1: 0,   y1: 0,   cidx: cidx_blue}
    };

    typedef enum logic [1:0] {idle, init, draw, done} seq_state_t;
    typedef enum logic [1:0] {ld_idle, ld_init, ld_draw} ld_state_t;

endpackage

`default_nettype wire

// File: src/disp_if.sv
/*
 * Raster position, data-enable and frame/line strobes from display timing
 * to the framebuffer readout.
 */
`default_nettype none

interface disp_if;

    display_pkg::coord_t sx;    // screen column
    display_pkg::coord_t sy;    // screen row
    logic                de;    // active video
    logic                frame; // pulse at (0,0)
    logic                line;  // pulse at sx == 0

    modport producer (output sx, sy, de, frame, line);
    modport consumer (input  sx, sy, de, frame, line);

endinterface

`default_nettype wire

// File: src/draw_if.sv
/*
 * Pixel write port from the line drawer into the framebuffer.
 * A write happens on every cycle with we high; busy holds the drawer off.
 */
`default_nettype none

interface draw_if;

    logic                       we;    // write strobe
    display_pkg::coord_t        x;     // fb column
    display_pkg::coord_t        y;     // fb row
    logic [draw_pkg::cidxw-1:0] cidx;  // colour index to store
    logic                       busy;  // port in use by readout or clear

    modport producer (output we, x, y, cidx, input  busy);
    modport consumer (input  we, x, y, cidx, output busy);

endinterface

`default_nettype wire

// File: src/display_timing.sv
/*
 * 640x480 raster counters. Screen position and strobes go out on disp,
 * syncs are decoded combinationally from the counters.
 */
`default_nettype none

module display_timing (
    input  wire logic clk_pix,
    input  wire logic rst,
    disp_if.producer  disp,
    output logic      hsync,
    output logic      vsync
);

    display_pkg::coord_t sx;
    display_pkg::coord_t sy;

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == display_pkg::h_total - 1) begin
            sx <= '0;
            if (sy == display_pkg::v_total - 1) begin
                sy <= '0;  // wrap to top of frame
            end else begin
                sy <= sy + display_pkg::cordw'(1);
            end
        end else begin
            sx <= sx + display_pkg::cordw'(1);
        end
    end

    always_comb begin
        disp.sx    = sx;
        disp.sy    = sy;
        disp.de    = (sx < display_pkg::h_active) && (sy < display_pkg::v_active);
        disp.frame = (sx == 0) && (sy == 0);
        disp.line  = (sx == 0);
    end

    // sync pulse follows the front porch
    always_comb begin
        if (sx >= display_pkg::h_active + display_pkg::h_front &&
            sx <  display_pkg::h_active + display_pkg::h_front + display_pkg::h_sync) begin
            hsync = display_pkg::sync_on;
        end else begin
            hsync = ~display_pkg::sync_on;
        end

        if (sy >= display_pkg::v_active + display_pkg::v_front &&
            sy <  display_pkg::v_active + display_pkg::v_front + display_pkg::v_sync) begin
            vsync = display_pkg::sync_on;
        end else begin
            vsync = ~display_pkg::sync_on;
        end
    end

endmodule

`default_nettype wire

// File: src/line_draw.sv
/*
 * Bresenham line rasteriser for any octant. Emits one pixel per cycle
 * while the framebuffer is free, then pulses done.
 */
`default_nettype none

module line_draw (
    input  wire logic                       clk_pix,
    input  wire logic                       rst,
    input  wire logic                       start,
    input  wire display_pkg::coord_t        x0,
    input  wire display_pkg::coord_t        y0,
    input  wire display_pkg::coord_t        x1,
    input  wire display_pkg::coord_t        y1,
    input  wire logic [draw_pkg::cidxw-1:0] cidx,
    draw_if.producer                        fb,
    output logic                            drawing,
    output logic                            done
);

    draw_pkg::ld_state_t state;

    display_pkg::coord_t xa, ya, xb, yb;   // endpoints, ya <= yb
    display_pkg::coord_t x, y;             // current pixel
    logic signed [display_pkg::cordw:0]   dx, dy, err;
    logic signed [display_pkg::cordw:0]   dx_n, dy_n;
    logic signed [display_pkg::cordw+1:0] e2;
    logic                                 right;  // x increases along the line
    logic                                 step_x, step_y;
    logic [draw_pkg::cidxw-1:0]           cidx_q;

    always_comb begin
        dx_n   = (xa < xb) ? xb - xa : xa - xb;
        dy_n   = ya - yb;           // never positive after the swap
        e2     = {err, 1'b0};
        step_x = (e2 >= dy);
        step_y = (e2 <= dx);
    end

    always_ff @(posedge clk_pix) begin
        done <= 1'b0;
        case (state)
            draw_pkg::ld_init: begin
                right <= (xa < xb);
                dx    <= dx_n;
                dy    <= dy_n;
                err   <= dx_n + dy_n;
                x     <= xa;
                y     <= ya;
                state <= draw_pkg::ld_draw;
            end
            draw_pkg::ld_draw: begin
                if (!fb.busy) begin
                    if (x == xb && y == yb) begin
                        done  <= 1'b1;  // last pixel went out this cycle
                        state <= draw_pkg::ld_idle;
                    end else begin
                        if (step_x) x <= right ? x + display_pkg::cordw'(1)
                                               : x - display_pkg::cordw'(1);
                        if (step_y) y <= y + display_pkg::cordw'(1);
                        err <= err + (step_x ? dy : '0) + (step_y ? dx : '0);
                    end
                end
            end
            default: begin
                if (start) begin
                    cidx_q <= cidx;
                    if (y0 > y1) begin  // always walk downwards
                        xa <= x1;
                        ya <= y1;
                        xb <= x0;
                        yb <= y0;
                    end else begin
                        xa <= x0;
                        ya <= y0;
                        xb <= x1;
                        yb <= y1;
                    end
                    state <= draw_pkg::ld_init;
                end
            end
        endcase
        if (rst) begin
            state <= draw_pkg::ld_idle;
            done  <= 1'b0;
        end
    end

    always_comb begin
        drawing = (state == draw_pkg::ld_draw) && !fb.busy;
        fb.we   = drawing;
        fb.x    = x;
        fb.y    = y;
        fb.cidx = cidx_q;
    end

endmodule

`default_nettype wire

// File: src/line_sequencer.sv
/*
 * Draw FSM: on the first frame pulse it hands the border lines to the
 * drawer one at a time, then holds draw_done until reset.
 */
`default_nettype none

module line_sequencer (
    input  wire logic                    clk_pix,
    input  wire logic                    rst,
    input  wire logic                    frame,
    input  wire logic                    done,
    output logic                         start,
    output display_pkg::coord_t          x0,
    output display_pkg::coord_t          y0,
    output display_pkg::coord_t          x1,
    output display_pkg::coord_t          y1,
    output logic [draw_pkg::cidxw-1:0]   cidx,
    output logic                         draw_done
);

    draw_pkg::seq_state_t             state;
    logic [draw_pkg::line_idw-1:0]    line_id;  // current table entry

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state     <= draw_pkg::idle;
            line_id   <= '0;
            start     <= 1'b0;
            draw_done <= 1'b0;
        end else begin
            case (state)
                draw_pkg::init: begin
                    start <= 1'b1;  // endpoints valid alongside start
                    x0    <= draw_pkg::line_table[line_id].x0;
                    y0    <= draw_pkg::line_table[line_id].y0;
                    x1    <= draw_pkg::line_table[line_id].x1;
                    y1    <= draw_pkg::line_table[line_id].y1;
                    cidx  <= draw_pkg::line_table[line_id].cidx;
                    state <= draw_pkg::draw;
                end
                draw_pkg::draw: begin
                    start <= 1'b0;
                    if (done) begin
                        if (line_id == draw_pkg::line_idw'(draw_pkg::line_cnt - 1)) begin
                            draw_done <= 1'b1;
                            state     <= draw_pkg::done;
                        end else begin
                            line_id <= line_id + 1'b1;
                            state   <= draw_pkg::init;
                        end
                    end
                end
                draw_pkg::done: begin
                    state <= draw_pkg::done;  // parked until reset
                end
                default: begin
                    if (frame) state <= draw_pkg::init;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/framebuffer.sv
/*
 * 320x180 indexed framebuffer on one shared port. Readout takes the port
 * on letterbox rows; draw writes and the reset clear use it otherwise.
 */
`default_nettype none

module framebuffer (
    input  wire logic                   clk_pix,
    input  wire logic                   rst,
    disp_if.consumer                    disp,
    draw_if.consumer                    fb,
    output logic [draw_pkg::chanw-1:0]  red,
    output logic [draw_pkg::chanw-1:0]  green,
    output logic [draw_pkg::chanw-1:0]  blue
);

    logic [draw_pkg::cidxw-1:0]    mem [draw_pkg::fb_pixels];
    logic [draw_pkg::fb_addrw-1:0] row_base, row_cur;  // start of current fb row
    logic [draw_pkg::fb_addrw-1:0] raddr, waddr, addr, clr_addr;
    logic [draw_pkg::cidxw-1:0]    wdata, rd_idx;
    logic [3*draw_pkg::chanw-1:0]  colour;
    logic lb_row, rd_active, row_step, wr_ok, wr_en;
    logic clearing;  // reset sweep in progress
    logic lb_q;      // rd_idx belongs to an image pixel

    always_comb begin
        lb_row    = (disp.sy >= display_pkg::lb_top) && (disp.sy < display_pkg::lb_bottom);
        rd_active = disp.de && lb_row;
        row_step  = lb_row && (disp.sy != display_pkg::lb_top) &&
                    ((disp.sy - display_pkg::lb_top) % draw_pkg::fb_scale == 0);

        // row base moves on at the start of each new fb row
        row_cur = row_base;
        if (disp.line) begin
            if (disp.sy == display_pkg::lb_top) begin
                row_cur = '0;
            end else if (row_step) begin
                row_cur = row_base + draw_pkg::fb_addrw'(draw_pkg::fb_width);
            end
        end
        raddr = row_cur + draw_pkg::fb_addrw'(disp.sx / draw_pkg::fb_scale);

        waddr = draw_pkg::fb_addrw'(fb.y) * draw_pkg::fb_addrw'(draw_pkg::fb_width) +
                draw_pkg::fb_addrw'(fb.x);
        wr_ok = fb.x >= 0 && fb.x < draw_pkg::fb_width &&
                fb.y >= 0 && fb.y < draw_pkg::fb_height;  // drop off-buffer pixels

        if (rd_active) begin
            addr = raddr;
        end else if (clearing) begin
            addr = clr_addr;
        end else begin
            addr = waddr;
        end
        wr_en   = !rd_active && (clearing || (fb.we && wr_ok));
        wdata   = clearing ? draw_pkg::cidx_black : fb.cidx;
        fb.busy = rd_active || clearing;
    end

    always_ff @(posedge clk_pix) begin
        if (rst || disp.frame) begin
            row_base <= '0;
        end else begin
            row_base <= row_cur;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            clearing <= 1'b1;
            clr_addr <= '0;
        end else if (clearing && !rd_active) begin
            if (clr_addr == draw_pkg::fb_addrw'(draw_pkg::fb_pixels - 1)) begin
                clearing <= 1'b0;
            end else begin
                clr_addr <= clr_addr + 1'b1;
            end
        end
    end

    // single port, read-before-write
    always_ff @(posedge clk_pix) begin
        if (wr_en) mem[addr] <= wdata;
        rd_idx <= mem[addr];
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            lb_q <= 1'b0;
        end else begin
            lb_q <= rd_active;
        end
    end

    always_comb begin
        colour = lb_q ? draw_pkg::palette[rd_idx] : '0;  // black outside image
        red    = colour[2*draw_pkg::chanw +: draw_pkg::chanw];
        green  = colour[draw_pkg::chanw   +: draw_pkg::chanw];
        blue   = colour[0                 +: draw_pkg::chanw];
    end

endmodule

`default_nettype wire

// File: src/latency_check_top.sv
/*
 * Top level: draws the border into the framebuffer and shows it on VGA.
 * Syncs are delayed two cycles to line up with the registered colour.
 */
`default_nettype none

module latency_check_top (
    input  wire logic                  clk_pix,
    input  wire logic                  rst,
    output logic                       vga_hsync,
    output logic                       vga_vsync,
    output logic [draw_pkg::chanw-1:0] vga_r,
    output logic [draw_pkg::chanw-1:0] vga_g,
    output logic [draw_pkg::chanw-1:0] vga_b,
    output logic                       draw_done
);

    disp_if disp_bus ();
    draw_if draw_bus ();

    logic hsync, vsync, hsync_p1, vsync_p1;
    logic draw_start, line_done;
    display_pkg::coord_t line_x0, line_y0, line_x1, line_y1;
    logic [draw_pkg::cidxw-1:0] line_cidx;
    logic [draw_pkg::chanw-1:0] fb_red, fb_green, fb_blue;

    display_timing timing_i (.clk_pix, .rst, .disp(disp_bus.producer), .hsync, .vsync);

    line_sequencer seq_i (
        .clk_pix, .rst,
        .frame(disp_bus.frame),
        .done(line_done),
        .start(draw_start),
        .x0(line_x0), .y0(line_y0), .x1(line_x1), .y1(line_y1),
        .cidx(line_cidx),
        .draw_done
    );

    line_draw draw_i (
        .clk_pix, .rst,
        .start(draw_start),
        .x0(line_x0), .y0(line_y0), .x1(line_x1), .y1(line_y1),
        .cidx(line_cidx),
        .fb(draw_bus.producer),
        .drawing(),  // write strobe travels on draw_bus
        .done(line_done)
    );

    framebuffer fb_i (
        .clk_pix, .rst,
        .disp(disp_bus.consumer),
        .fb(draw_bus.consumer),
        .red(fb_red), .green(fb_green), .blue(fb_blue)
    );

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            hsync_p1  <= ~display_pkg::sync_on;
            vsync_p1  <= ~display_pkg::sync_on;
            vga_hsync <= ~display_pkg::sync_on;
            vga_vsync <= ~display_pkg::sync_on;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            hsync_p1  <= hsync;     // matches fb read cycle
            vsync_p1  <= vsync;
            vga_hsync <= hsync_p1;  // matches output register
            vga_vsync <= vsync_p1;
            vga_r     <= fb_red;
            vga_g     <= fb_green;
            vga_b     <= fb_blue;
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_checker.sv
/*
 * Watches the VGA pins, rebuilds the raster position from the sync edges
 * and runs the comparisons that tb_top requests through go/test_id.
 */
`default_nettype none

module tb_checker (
    input  wire logic                       clk_pix,
    input  wire logic                       rst,
    input  wire logic                       vga_hsync,
    input  wire logic                       vga_vsync,
    input  wire logic [draw_pkg::chanw-1:0] vga_r,
    input  wire logic [draw_pkg::chanw-1:0] vga_g,
    input  wire logic [draw_pkg::chanw-1:0] vga_b,
    input  wire logic                       draw_done,
    input  wire logic                       go,
    input  wire logic [2:0]                 test_id,
    input  wire logic [15:0]                vec [96],
    output logic                            fin,
    output int                              err_total,
    output int                              tests_passed,
    output int                              tests_failed
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int line_cycles  = int'(display_pkg::h_total);
    localparam int frame_lines  = int'(display_pkg::v_total);
    localparam int frame_cycles = line_cycles * frame_lines;
    localparam int hs_start     = int'(display_pkg::h_active + display_pkg::h_front);
    localparam int vs_start     = int'(display_pkg::v_active + display_pkg::v_front);
    localparam int probe_max    = 32;

    event sampled;              // fires after each sample is tracked
    int   px, py;               // position of the current sample
    logic locked;               // position valid after first vsync edge
    logic hs_q, vs_q, h_fell, v_fell;
    int   since_rst, done_at;
    logic done_dropped;
    logic drop_told;
    int   shown;                // error lines printed in this test

    // colour and sync are aligned at the pins, so no offset is needed
    always @(negedge clk_pix) begin
        if (rst) begin
            px           = 0;
            py           = 0;
            locked       = 1'b0;
            hs_q         = 1'b1;
            vs_q         = 1'b1;
            h_fell       = 1'b0;
            v_fell       = 1'b0;
            since_rst    = 0;
            done_at      = -1;
            done_dropped = 1'b0;
        end else begin
            h_fell = hs_q && !vga_hsync;
            v_fell = vs_q && !vga_vsync;
            if (h_fell) begin
                px = hs_start;
            end else if (px == line_cycles - 1) begin
                px = 0;
                py = (py == frame_lines - 1) ? 0 : py + 1;
            end else begin
                px++;
            end
            if (v_fell) begin
                py     = vs_start;  // vsync falls at the start of this row
                locked = 1'b1;
            end
            if (draw_done && done_at < 0) done_at = since_rst;
            if (!draw_done && done_at >= 0) done_dropped = 1'b1;
            since_rst++;
            hs_q = vga_hsync;
            vs_q = vga_vsync;
        end
        -> sampled;
    end

    task automatic report(input string msg);
        err_total++;
        if (shown < 8) $display("%s", msg);
        shown++;
    endtask

    task automatic compare(input string sig, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            report($sformatf("mismatch %s: got 0x%0h expected 0x%0h", sig, got, exp));
        end
    endtask

    task automatic colour_at(input logic [11:0] exp);
        string at;
        if ({vga_r, vga_g, vga_b} !== exp) begin
            at = $sformatf(" at (%0d,%0d)", px, py);
            compare({"vga_r", at}, vga_r, exp[2*draw_pkg::chanw +: draw_pkg::chanw]);
            compare({"vga_g", at}, vga_g, exp[draw_pkg::chanw +: draw_pkg::chanw]);
            compare({"vga_b", at}, vga_b, exp[0 +: draw_pkg::chanw]);
        end
    endtask

    task automatic wait_pos(input int x, input int y, output logic found);
        int n;
        n     = 0;
        found = locked && px == x && py == y;
        while (!found && n < frame_cycles + line_cycles) begin
            @(sampled);
            n++;
            found = locked && px == x && py == y;
        end
    endtask

    function automatic logic sync_fell(input logic vert);
        return vert ? v_fell : h_fell;
    endfunction

    function automatic logic sync_level(input logic vert);
        return vert ? vga_vsync : vga_hsync;
    endfunction

    // cycles from one falling edge to the next, and how many of them are low
    task automatic measure_sync(input logic vert, output int low_len, output int period);
        int n;
        int lows;
        n       = 0;
        lows    = 1;
        low_len = -1;
        period  = -1;
        while (!sync_fell(vert) && n < 2 * frame_cycles) begin
            @(sampled);
            n++;
        end
        if (sync_fell(vert)) begin
            n = 0;
            do begin
                @(sampled);
                n++;
                if (!sync_fell(vert) && !sync_level(vert)) lows++;
            end while (!sync_fell(vert) && n < 2 * frame_cycles);
            if (sync_fell(vert)) begin
                low_len = lows;
                period  = n;
            end
        end
    endtask

    task automatic reset_values();
        compare("draw_done", draw_done, 1'b0);
        compare("vga_hsync", vga_hsync, 1'b1);
        compare("vga_vsync", vga_vsync, 1'b1);
        colour_at(12'h000);
    endtask

    task automatic sync_timing();
        int low_len;
        int period;
        measure_sync(1'b0, low_len, period);
        if (period < 0) begin
            report("vga_hsync did not show two falling edges");
        end else begin
            compare("vga_hsync period", period, line_cycles);
            compare("vga_hsync low width", low_len, int'(display_pkg::h_sync));
        end
        measure_sync(1'b1, low_len, period);
        if (period < 0) begin
            report("vga_vsync did not show two falling edges");
        end else begin
            compare("vga_vsync period", period, frame_cycles);
            compare("vga_vsync low width", low_len, int'(display_pkg::v_sync) * line_cycles);
        end
    endtask

    task automatic completion();
        int n;
        n = 0;
        while (done_at < 0 && since_rst < 3 * frame_cycles && n < 3 * frame_cycles) begin
            @(sampled);
            n++;
        end
        if (done_at < 0 || done_at >= 3 * frame_cycles) begin
            report("draw_done did not rise within three frames");
        end else begin
            compare("draw_done", draw_done, 1'b1);
        end
    endtask

    task automatic letterbox_black();
        logic found;
        int   n;
        wait_pos(0, 0, found);
        if (!found) begin
            report("raster position (0,0) never came around");
        end else begin
            for (n = 0; n < frame_cycles; n++) begin
                if (px < display_pkg::h_active &&
                    (py < display_pkg::lb_top ||
                     (py >= display_pkg::lb_bottom && py < display_pkg::v_active))) begin
                    colour_at(12'h000);
                end
                @(sampled);
            end
        end
    endtask

    task automatic probe_pixels();
        int   i;
        logic found;
        for (i = 0; i < probe_max && int'(vec[3*i]) < int'(display_pkg::h_active); i++) begin
            wait_pos(int'(vec[3*i]), int'(vec[3*i+1]), found);
            if (!found) begin
                report($sformatf("probe %0d at (%0d,%0d) was never reached",
                                 i, vec[3*i], vec[3*i+1]));
            end else begin
                colour_at(vec[3*i+2][11:0]);
            end
        end
        if (i == 0) report("no probes were loaded from the vector file");
    endtask

    task automatic run_check(input logic [2:0] id);
        int    errs_before;
        string name;
        errs_before = err_total;
        shown       = 0;
        case (id)
            3'd1:    begin name = "after reset";   reset_values();    end
            3'd2:    begin name = "sync timing";   sync_timing();     end
            3'd3:    begin name = "completion";    completion();      end
            3'd4:    begin name = "letterbox";     letterbox_black(); end
            default: begin name = "vector probes"; probe_pixels();    end
        endcase
        if (done_dropped && !drop_told) begin
            $display("draw_done went low again after it had risen");
            err_total++;
            drop_told = 1'b1;
        end
        if (err_total == errs_before) begin
            tests_passed++;
            $display("test %0d %s: ok", id, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", id, name, err_total - errs_before);
        end
    endtask

    initial begin
        fin          = 1'b0;
        err_total    = 0;
        tests_passed = 0;
        tests_failed = 0;
        shown        = 0;
        drop_told    = 1'b0;
        forever begin
            @(sampled);
            if (!go) begin
                fin = 1'b0;
            end else if (!fin) begin
                run_check(test_id);
                fin = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_top.sv
/*
 * Testbench top: clock, reset, DUT and vector loading. Runs the checks in
 * tb_checker one after another and prints the closing counts and verdict.
 */
`default_nettype none

module tb_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int test_cnt     = 5;
    localparam int frame_cycles = int'(display_pkg::h_total) * int'(display_pkg::v_total);
    localparam int test_limit   = 24 * frame_cycles;  // generous per-test bound

    logic                       clk_pix = 1'b0;
    logic                       rst;
    logic                       vga_hsync, vga_vsync, draw_done;
    logic [draw_pkg::chanw-1:0] vga_r, vga_g, vga_b;
    logic                       go;
    logic [2:0]                 test_id;
    logic                       fin;
    int                         err_total, tests_passed, tests_failed;
    logic [15:0]                vec_mem [96];  // 3 words per probe
    logic                       hung;

    always #50 clk_pix = ~clk_pix;  // 100 ns period

    latency_check_top dut_i (
        .clk_pix   (clk_pix),
        .rst       (rst),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b),
        .draw_done (draw_done)
    );

    tb_checker checker_i (
        .clk_pix, .rst, .vga_hsync, .vga_vsync, .vga_r, .vga_g, .vga_b, .draw_done,
        .go, .test_id,
        .vec (vec_mem),
        .fin, .err_total, .tests_passed, .tests_failed
    );

    // hand one test to the checker and wait for it to report back
    task automatic run_test(input logic [2:0] id);
        int waited;
        waited  = 0;
        test_id <= id;
        go      <= 1'b1;
        do begin
            @(posedge clk_pix);
            waited++;
        end while (!fin && waited < test_limit);
        go <= 1'b0;
        if (!fin) begin
            $display("test %0d did not finish within %0d cycles", id, test_limit);
            hung = 1'b1;
        end else begin
            waited = 0;
            while (fin && waited < 8) begin
                @(posedge clk_pix);
                waited++;
            end
            if (fin) begin
                $display("checker did not release its finish flag after test %0d", id);
                hung = 1'b1;
            end
        end
    endtask

    initial begin
        int i;
        int id;
        rst     = 1'b1;
        go      = 1'b0;
        test_id = '0;
        hung    = 1'b0;
        for (i = 0; i < 96; i++) begin
            vec_mem[i] = 16'hfc00 | 16'(i);  // off-screen x marks unused probe slots
        end
        $readmemh("tests/test_vectors.txt", vec_mem);

        repeat (3) @(posedge clk_pix);
        rst <= 1'b0;

        for (id = 1; id <= test_cnt; id++) begin
            if (!hung) run_test(3'(id));
        end

        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, err_total);
        if (!hung && tests_failed == 0 && tests_passed == test_cnt) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/test_vectors.txt
// columns: screen x, screen y, expected 12-bit colour (rgb), all hex
// probes are in raster order so a single frame reaches all of them
0000 003c 00f
00c8 003c f00
027f 003c ff0
00c9 003d f00
0002 003e 000
0000 00f0 00f
0140 00f0 000
027e 00f0 ff0
0001 00f1 00f
027f 00f1 ff0
027d 01a1 000
0140 01a2 0f0
0000 01a3 00f
0141 01a3 0f0
027f 01a3 0f0

// File: all.f
src/display_pkg.sv
src/draw_pkg.sv
src/disp_if.sv
src/draw_if.sv
src/display_timing.sv
src/line_draw.sv
src/line_sequencer.sv
src/framebuffer.sv
src/latency_check_top.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: Makefile
# Verilator build and run for the VGA line drawing project

VERILATOR  ?= verilator
TOP        ?= tb_top
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= TEST PASS
TIMESCALE  ?= 1ns/100ps
VFLAGS     ?= --binary --timing --timescale $(TIMESCALE) -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --timescale $(TIMESCALE) -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
